// ==== logic/rvIsaPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// RV32I encodings: opcodes, funct3 codes and immediate formats
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package rvIsaPkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeT;

    // funct3 of register and immediate ALU operations
    typedef enum logic [2:0] {
        f3AddSub = 3'b000,
        f3Sll    = 3'b001,
        f3Slt    = 3'b010,
        f3Sltu   = 3'b011,
        f3Xor    = 3'b100,
        f3Srl    = 3'b101,
        f3Or     = 3'b110,
        f3And    = 3'b111
    } funct3T;

    // branch codes share encodings with the ALU codes
    localparam funct3T f3Beq = f3AddSub;
    localparam funct3T f3Bne = f3Sll;

    // immediate layouts
    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immU = 3'd3,
        immJ = 3'd4
    } immSrcT;

    // addi x0, x0, 0
    localparam logic [31:0] nopInstr = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== logic/coreCtrlPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// control FSM states, ALU operations and datapath mux selects
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package coreCtrlPkg;

    typedef enum logic [3:0] {
        stFetch,
        stFetchWait,
        stDecode,
        stExecR,
        stExecI,
        stLui,
        stJal,
        stBranch,
        stMemAdr,
        stMemRead,
        stMemWrite,
        stLoadWb,
        stAluWb
    } stateT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra
    } aluOpT;

    typedef enum logic [1:0] {srcAPc, srcAOldPc, srcAReg, srcAZero} srcASelT;

    typedef enum logic [1:0] {srcBReg, srcBImm, srcBFour} srcBSelT;

    // ALU-out register, load data, or the ALU result of this cycle
    typedef enum logic [1:0] {resAluOut, resData, resAluResult} resultSelT;

endpackage

`default_nettype wire

// ==== logic/registerFile.sv ====
////////////////////////////////////////////////////////////////////////////
// integer register file, two read ports and one write port
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module registerFile #(
    parameter int numRegs = 32
) (
    input  wire         clk,
    input  wire         we,
    input  wire  [4:0]  raddr1,
    input  wire  [4:0]  raddr2,
    input  wire  [4:0]  waddr,
    input  wire  [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    localparam int idxW = $clog2(numRegs);

    logic [31:0] regs [numRegs];

    always_ff @(posedge clk) begin
        // x0 is never stored
        if (we && waddr != 5'd0) begin
            regs[waddr[idxW-1:0]] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1[idxW-1:0]];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2[idxW-1:0]];

    // decoder must not target registers beyond the configured count
    assert property (@(posedge clk) we |-> (waddr < numRegs));

endmodule

`default_nettype wire

// ==== logic/aluUnit.sv ====
////////////////////////////////////////////////////////////////////////////
// combinational ALU with zero flag
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module aluUnit (
    input  wire                [31:0] srcA,
    input  wire                [31:0] srcB,
    input  coreCtrlPkg::aluOpT        aluOp,
    output logic               [31:0] result,
    output logic                      zero
);

    logic [4:0] shamt;

    assign shamt = srcB[4:0];

    always_comb begin
        case (aluOp)
            coreCtrlPkg::aluAdd:  result = srcA + srcB;
            coreCtrlPkg::aluSub:  result = srcA - srcB;
            coreCtrlPkg::aluAnd:  result = srcA & srcB;
            coreCtrlPkg::aluOr:   result = srcA | srcB;
            coreCtrlPkg::aluXor:  result = srcA ^ srcB;
            coreCtrlPkg::aluSlt:  result = {31'd0, $signed(srcA) < $signed(srcB)};
            coreCtrlPkg::aluSltu: result = {31'd0, srcA < srcB};
            coreCtrlPkg::aluSll:  result = srcA << shamt;
            coreCtrlPkg::aluSrl:  result = srcA >> shamt;
            // arithmetic shift keeps the sign bit
            coreCtrlPkg::aluSra:  result = $unsigned($signed(srcA) >>> shamt);
            default:              result = srcA + srcB;
        endcase
    end

    // beq and bne use this after a subtract
    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== logic/immExtend.sv ====
////////////////////////////////////////////////////////////////////////////
// immediate rebuild and sign extension for I, S, B, U and J formats
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module immExtend (
    input  wire              [24:0] instrBits,
    input  rvIsaPkg::immSrcT        immSrc,
    output logic             [31:0] immExt
);

    logic sign;

    // instrBits[k] is instruction bit k+7
    assign sign = instrBits[24];

    always_comb begin
        case (immSrc)
            rvIsaPkg::immI: immExt = {{20{sign}}, instrBits[24:13]};
            rvIsaPkg::immS: immExt = {{20{sign}}, instrBits[24:18], instrBits[4:0]};
            rvIsaPkg::immB: immExt = {{20{sign}}, instrBits[0], instrBits[23:18],
                                      instrBits[4:1], 1'b0};
            rvIsaPkg::immU: immExt = {instrBits[24:5], 12'd0};
            rvIsaPkg::immJ: immExt = {{12{sign}}, instrBits[12:5], instrBits[13],
                                      instrBits[23:14], 1'b0};
            default:        immExt = {{20{sign}}, instrBits[24:13]};
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/datapathUnit.sv ====
////////////////////////////////////////////////////////////////////////////
// multicycle datapath: PC, instruction and intermediate registers,
// operand and result muxes, memory address and write data
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module datapathUnit #(
    parameter logic [31:0] resetAddr = 32'd0,
    parameter int          numRegs   = 32
) (
    input  wire                           clk,
    input  wire                           rst,

    input  wire                           pcWrite,
    input  wire                           adrSrc,
    input  wire                           irWrite,
    input  wire                           regWrite,
    input  wire                           aluOutWrite,
    input  rvIsaPkg::immSrcT              immSrc,
    input  coreCtrlPkg::srcASelT          srcASel,
    input  coreCtrlPkg::srcBSelT          srcBSel,
    input  coreCtrlPkg::resultSelT        resultSel,
    input  coreCtrlPkg::aluOpT            aluOp,

    output logic                   [6:0]  opcode,
    output logic                   [2:0]  funct3,
    output logic                          funct7b5,
    output logic                          zero,

    input  wire                    [31:0] memRdata,
    output logic                   [31:0] memAddr,
    output logic                   [31:0] memWdata,

    output logic                   [31:0] pc,
    output logic                   [31:0] oldPc,
    output logic                   [4:0]  regWaddr,
    output logic                   [31:0] regWdata
);

    logic [31:0] instr;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] aReg;
    logic [31:0] bReg;
    logic [31:0] immExt;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] aluResult;
    logic [31:0] aluOut;
    logic [31:0] dataReg;
    logic [31:0] result;

    // instruction fields back to control
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // architectural state and the fetched instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= resetAddr;
            oldPc <= resetAddr;
            instr <= rvIsaPkg::nopInstr;
        end else begin
            if (pcWrite) begin
                pc <= result;
            end
            // old PC follows the instruction it belongs to
            if (irWrite) begin
                instr <= memRdata;
                oldPc <= pc;
            end
        end
    end

    // operand and load data registers sample every cycle
    always_ff @(posedge clk) begin
        aReg    <= rd1;
        bReg    <= rd2;
        dataReg <= memRdata;
        if (aluOutWrite) begin
            aluOut <= aluResult;
        end
    end

    registerFile #(
        .numRegs(numRegs)
    ) i_regFile (
        .clk   (clk),
        .we    (regWrite),
        .raddr1(instr[19:15]),
        .raddr2(instr[24:20]),
        .waddr (instr[11:7]),
        .wdata (result),
        .rdata1(rd1),
        .rdata2(rd2)
    );

    immExtend i_immExtend (
        .instrBits(instr[31:7]),
        .immSrc   (immSrc),
        .immExt   (immExt)
    );

    always_comb begin
        case (srcASel)
            coreCtrlPkg::srcAPc:    srcA = pc;
            coreCtrlPkg::srcAOldPc: srcA = oldPc;
            coreCtrlPkg::srcAReg:   srcA = aReg;
            default:                srcA = 32'd0;
        endcase
    end

    always_comb begin
        case (srcBSel)
            coreCtrlPkg::srcBReg:  srcB = bReg;
            coreCtrlPkg::srcBImm:  srcB = immExt;
            coreCtrlPkg::srcBFour: srcB = 32'd4;
            default:               srcB = 32'd0;
        endcase
    end

    aluUnit i_alu (
        .srcA  (srcA),
        .srcB  (srcB),
        .aluOp (aluOp),
        .result(aluResult),
        .zero  (zero)
    );

    // result drives the write port and the next PC alike
    always_comb begin
        case (resultSel)
            coreCtrlPkg::resData:      result = dataReg;
            coreCtrlPkg::resAluResult: result = aluResult;
            default:                   result = aluOut;
        endcase
    end

    assign memAddr  = adrSrc ? result : pc;
    assign memWdata = bReg;
    assign regWaddr = instr[11:7];
    assign regWdata = result;

    // fetch enables come from the FSM and must never float
    assert property (@(posedge clk) disable iff (rst) !$isunknown({irWrite, pcWrite}));

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
////////////////////////////////////////////////////////////////////////////
// multicycle control FSM with main decode and ALU decode
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module controlUnit (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                    [6:0]  opcode,
    input  wire                    [2:0]  funct3,
    input  wire                           funct7b5,
    input  wire                           zero,
    output logic                          pcWrite,
    output logic                          adrSrc,
    output logic                          irWrite,
    output logic                          regWrite,
    output logic                          aluOutWrite,
    output rvIsaPkg::immSrcT              immSrc,
    output coreCtrlPkg::srcASelT          srcASel,
    output coreCtrlPkg::srcBSelT          srcBSel,
    output coreCtrlPkg::resultSelT        resultSel,
    output coreCtrlPkg::aluOpT            aluOp,
    output logic                          memRead,
    output logic                          memWrite,
    output logic                          retire
);

    coreCtrlPkg::stateT state;
    coreCtrlPkg::stateT nextState;
    coreCtrlPkg::aluOpT aluDec;
    logic               isLoad;
    logic               takeBranch;

    assign isLoad = (opcode == rvIsaPkg::opLoad);

    // beq on zero, bne otherwise
    assign takeBranch = (funct3 == rvIsaPkg::f3Beq) ? zero : !zero;

    // immediate format only depends on the opcode
    always_comb begin
        case (opcode)
            rvIsaPkg::opStore:  immSrc = rvIsaPkg::immS;
            rvIsaPkg::opBranch: immSrc = rvIsaPkg::immB;
            rvIsaPkg::opLui:    immSrc = rvIsaPkg::immU;
            rvIsaPkg::opJal:    immSrc = rvIsaPkg::immJ;
            default:            immSrc = rvIsaPkg::immI;
        endcase
    end

    // ALU decode, sub only for register ops
    always_comb begin
        case (funct3)
            rvIsaPkg::f3AddSub: aluDec = (opcode == rvIsaPkg::opReg && funct7b5) ?
                                         coreCtrlPkg::aluSub : coreCtrlPkg::aluAdd;
            rvIsaPkg::f3Sll:    aluDec = coreCtrlPkg::aluSll;
            rvIsaPkg::f3Slt:    aluDec = coreCtrlPkg::aluSlt;
            rvIsaPkg::f3Sltu:   aluDec = coreCtrlPkg::aluSltu;
            rvIsaPkg::f3Xor:    aluDec = coreCtrlPkg::aluXor;
            rvIsaPkg::f3Srl:    aluDec = funct7b5 ? coreCtrlPkg::aluSra : coreCtrlPkg::aluSrl;
            rvIsaPkg::f3Or:     aluDec = coreCtrlPkg::aluOr;
            default:            aluDec = coreCtrlPkg::aluAnd;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= coreCtrlPkg::stFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = coreCtrlPkg::stFetch;
        case (state)
            coreCtrlPkg::stFetch:     nextState = coreCtrlPkg::stFetchWait;
            coreCtrlPkg::stFetchWait: nextState = coreCtrlPkg::stDecode;
            coreCtrlPkg::stDecode: begin
                case (opcode)
                    rvIsaPkg::opReg:    nextState = coreCtrlPkg::stExecR;
                    rvIsaPkg::opImm:    nextState = coreCtrlPkg::stExecI;
                    rvIsaPkg::opLui:    nextState = coreCtrlPkg::stLui;
                    rvIsaPkg::opJal:    nextState = coreCtrlPkg::stJal;
                    rvIsaPkg::opBranch: nextState = coreCtrlPkg::stBranch;
                    rvIsaPkg::opLoad:   nextState = coreCtrlPkg::stMemAdr;
                    rvIsaPkg::opStore:  nextState = coreCtrlPkg::stMemAdr;
                    default:            nextState = coreCtrlPkg::stFetch;
                endcase
            end
            coreCtrlPkg::stExecR:   nextState = coreCtrlPkg::stAluWb;
            coreCtrlPkg::stExecI:   nextState = coreCtrlPkg::stAluWb;
            coreCtrlPkg::stJal:     nextState = coreCtrlPkg::stAluWb;
            coreCtrlPkg::stMemAdr:  nextState = isLoad ? coreCtrlPkg::stMemRead :
                                                         coreCtrlPkg::stMemWrite;
            coreCtrlPkg::stMemRead: nextState = coreCtrlPkg::stLoadWb;
            default:                nextState = coreCtrlPkg::stFetch;
        endcase
    end

    // main decode per state
    always_comb begin
        pcWrite     = 1'b0;
        adrSrc      = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        aluOutWrite = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        retire      = 1'b0;
        srcASel     = coreCtrlPkg::srcAPc;
        srcBSel     = coreCtrlPkg::srcBFour;
        resultSel   = coreCtrlPkg::resAluOut;
        aluOp       = coreCtrlPkg::aluAdd;
        case (state)
            coreCtrlPkg::stFetch: memRead = 1'b1;
            coreCtrlPkg::stFetchWait: begin
                // latch instruction, pc <= pc + 4
                irWrite   = 1'b1;
                pcWrite   = 1'b1;
                resultSel = coreCtrlPkg::resAluResult;
            end
            coreCtrlPkg::stDecode: begin
                // branch and jal target
                srcASel     = coreCtrlPkg::srcAOldPc;
                srcBSel     = coreCtrlPkg::srcBImm;
                aluOutWrite = 1'b1;
            end
            coreCtrlPkg::stExecR: begin
                srcASel     = coreCtrlPkg::srcAReg;
                srcBSel     = coreCtrlPkg::srcBReg;
                aluOp       = aluDec;
                aluOutWrite = 1'b1;
            end
            coreCtrlPkg::stExecI: begin
                srcASel     = coreCtrlPkg::srcAReg;
                srcBSel     = coreCtrlPkg::srcBImm;
                aluOp       = aluDec;
                aluOutWrite = 1'b1;
            end
            coreCtrlPkg::stLui: begin
                srcASel   = coreCtrlPkg::srcAZero;
                srcBSel   = coreCtrlPkg::srcBImm;
                resultSel = coreCtrlPkg::resAluResult;
                regWrite  = 1'b1;
                retire    = 1'b1;
            end
            coreCtrlPkg::stJal: begin
                // jump to target, keep the link in ALU-out
                pcWrite     = 1'b1;
                srcASel     = coreCtrlPkg::srcAOldPc;
                aluOutWrite = 1'b1;
            end
            coreCtrlPkg::stBranch: begin
                srcASel = coreCtrlPkg::srcAReg;
                srcBSel = coreCtrlPkg::srcBReg;
                aluOp   = coreCtrlPkg::aluSub;
                pcWrite = takeBranch;
                retire  = 1'b1;
            end
            coreCtrlPkg::stMemAdr: begin
                // address goes out directly so loads can read now
                srcASel     = coreCtrlPkg::srcAReg;
                srcBSel     = coreCtrlPkg::srcBImm;
                resultSel   = coreCtrlPkg::resAluResult;
                adrSrc      = 1'b1;
                aluOutWrite = 1'b1;
                memRead     = isLoad;
            end
            coreCtrlPkg::stMemWrite: begin
                adrSrc   = 1'b1;
                memWrite = 1'b1;
                retire   = 1'b1;
            end
            coreCtrlPkg::stLoadWb: begin
                resultSel = coreCtrlPkg::resData;
                regWrite  = 1'b1;
                retire    = 1'b1;
            end
            coreCtrlPkg::stAluWb: begin
                regWrite = 1'b1;
                retire   = 1'b1;
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst)
        state inside {[coreCtrlPkg::stFetch : coreCtrlPkg::stAluWb]});

    // a store always follows its address cycle
    assert property (@(posedge clk) disable iff (rst)
        memWrite |-> (state == coreCtrlPkg::stMemWrite && $past(state) == coreCtrlPkg::stMemAdr));

endmodule

`default_nettype wire

// ==== logic/rvMultiCore.sv ====
////////////////////////////////////////////////////////////////////////////
// multicycle RV32I core: control FSM joined to the datapath
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module rvMultiCore #(
    parameter logic [31:0] resetAddr = 32'd0,
    parameter int          numRegs   = 32
) (
    input  wire         clk,
    input  wire         rst,
    output wire  [31:0] memAddr,
    output wire  [31:0] memWdata,
    output wire  [3:0]  memWstrb,
    output wire         memRead,
    input  wire  [31:0] memRdata,
    output wire         retire,
    output wire  [31:0] retirePc,
    output wire         regWe,
    output wire  [4:0]  regWaddr,
    output wire  [31:0] regWdata
);

    wire                    pcWrite;
    wire                    adrSrc;
    wire                    irWrite;
    wire                    aluOutWrite;
    wire                    memWrite;
    wire [6:0]              opcode;
    wire [2:0]              funct3;
    wire                    funct7b5;
    wire                    zero;
    rvIsaPkg::immSrcT       immSrc;
    coreCtrlPkg::srcASelT   srcASel;
    coreCtrlPkg::srcBSelT   srcBSel;
    coreCtrlPkg::resultSelT resultSel;
    coreCtrlPkg::aluOpT     aluOp;

    // word stores only
    assign memWstrb = {4{memWrite}};

    controlUnit i_ctrl (
        .clk(clk), .rst(rst),
        .opcode(opcode), .funct3(funct3), .funct7b5(funct7b5), .zero(zero),
        .pcWrite(pcWrite), .adrSrc(adrSrc), .irWrite(irWrite), .regWrite(regWe),
        .aluOutWrite(aluOutWrite), .immSrc(immSrc), .srcASel(srcASel),
        .srcBSel(srcBSel), .resultSel(resultSel), .aluOp(aluOp),
        .memRead(memRead), .memWrite(memWrite), .retire(retire)
    );

    datapathUnit #(
        .resetAddr(resetAddr),
        .numRegs  (numRegs)
    ) i_datapath (
        .clk(clk), .rst(rst),
        .pcWrite(pcWrite), .adrSrc(adrSrc), .irWrite(irWrite), .regWrite(regWe),
        .aluOutWrite(aluOutWrite), .immSrc(immSrc), .srcASel(srcASel),
        .srcBSel(srcBSel), .resultSel(resultSel), .aluOp(aluOp),
        .opcode(opcode), .funct3(funct3), .funct7b5(funct7b5), .zero(zero),
        .memRdata(memRdata), .memAddr(memAddr), .memWdata(memWdata),
        .pc(), .oldPc(retirePc), .regWaddr(regWaddr), .regWdata(regWdata)
    );

endmodule

`default_nettype wire

// ==== dv/tbIsaModel.svh ====
////////////////////////////////////////////////////////////////////////////
// random program generator, RV32I reference model and compare tasks
////////////////////////////////////////////////////////////////////////////
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

logic [31:0] modelPc;
logic [31:0] modelRegs [32];
logic [31:0] modelMem [memWords];
logic        expWe;
logic [4:0]  expRd;
logic [31:0] expVal;
logic        expStore;
logic [31:0] expAddr;
logic [31:0] expData;

function automatic logic [31:0] lcgNext();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
endfunction

// upper half only, the low bits of an LCG repeat quickly
function automatic int randBelow(int n);
    logic [31:0] r;
    r = lcgNext();
    return int'(r[31:16]) % n;
endfunction

function automatic logic [31:0] encI(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                     logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] encS(logic [4:0] rs2, logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rvIsaPkg::opStore};
endfunction

function automatic logic [31:0] encB(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                     logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvIsaPkg::opBranch};
endfunction

function automatic logic [31:0] encJ(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::opJal};
endfunction

task automatic buildProgram();
    int                 i;
    int                 span;
    logic [31:0]        r;
    logic [31:0]        w;
    logic [2:0]         f3;
    logic [11:0]        dataOff;
    rvIsaPkg::funct3T   immOps [5];
    immOps = '{rvIsaPkg::f3AddSub, rvIsaPkg::f3Slt, rvIsaPkg::f3Xor,
               rvIsaPkg::f3Or, rvIsaPkg::f3And};
    for (i = 0; i < progLen; i++) begin
        r = lcgNext();
        span = (progLen - 1 - i < 8) ? progLen - 1 - i : 8;
        // data region sits at 0x400, above the program
        dataOff = 12'h400 + 12'(4 * randBelow(256));
        f3 = 3'(randBelow(8));
        if (i < 31) begin
            // prologue gives every register a defined value
            w = {r[31:12], 5'(i + 1), rvIsaPkg::opLui};
        end else if (i == progLen - 1) begin
            // halt, jal x0 to itself
            w = encJ(5'd0, 21'd0);
        end else begin
            case (randBelow(8))
                0, 1: w = {1'b0, (f3 == 3'd0 || f3 == 3'd5) & r[16], 5'd0, r[21:17],
                           r[26:22], f3, r[31:27], rvIsaPkg::opReg};
                2: w = encI(rvIsaPkg::opImm, immOps[randBelow(5)], r[31:27], r[26:22],
                            r[15:4]);
                3: w = {r[31:12], r[11:7], rvIsaPkg::opLui};
                // equal sources now and then so beq gets taken
                4: w = encB({2'b00, r[3]}, r[26:22], r[2] ? r[26:22] : r[21:17],
                            13'(4 * (1 + randBelow(span))));
                5: w = encJ(r[31:27], 21'(4 * (1 + randBelow(span))));
                6: w = encI(rvIsaPkg::opLoad, 3'b010, r[31:27], 5'd0, dataOff);
                default: w = encS(r[21:17], dataOff);
            endcase
        end
        mem[resetAddr[11:2] + 10'(i)] = w;
    end
endtask

function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
                                       logic [31:0] b);
    case (f3)
        rvIsaPkg::f3AddSub: return alt ? a - b : a + b;
        rvIsaPkg::f3Sll:    return a << b[4:0];
        // signs differ, so the negative one is smaller
        rvIsaPkg::f3Slt:    return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
        rvIsaPkg::f3Sltu:   return {31'd0, a < b};
        rvIsaPkg::f3Xor:    return a ^ b;
        rvIsaPkg::f3Srl:    return (a >> b[4:0]) |
                                   ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
        rvIsaPkg::f3Or:     return a | b;
        default:            return a & b;
    endcase
endfunction

task automatic stepModel();
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] addr;
    logic [31:0] nextPc;
    instr    = modelMem[modelPc[11:2]];
    a        = modelRegs[instr[19:15]];
    b        = modelRegs[instr[24:20]];
    immI     = {{20{instr[31]}}, instr[31:20]};
    addr     = a + immI;
    nextPc   = modelPc + 32'd4;
    expWe    = 1'b1;
    expRd    = instr[11:7];
    expVal   = 32'd0;
    expStore = 1'b0;
    case (instr[6:0])
        rvIsaPkg::opReg:  expVal = aluRef(instr[14:12], instr[30], a, b);
        rvIsaPkg::opImm:  expVal = aluRef(instr[14:12], 1'b0, a, immI);
        rvIsaPkg::opLui:  expVal = {instr[31:12], 12'd0};
        rvIsaPkg::opLoad: expVal = modelMem[addr[11:2]];
        rvIsaPkg::opJal: begin
            expVal = modelPc + 32'd4;
            nextPc = modelPc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
        end
        rvIsaPkg::opBranch: begin
            expWe = 1'b0;
            // funct3 bit 0 turns beq into bne
            if ((a == b) != instr[12]) begin
                nextPc = modelPc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                    instr[11:8], 1'b0};
            end
        end
        rvIsaPkg::opStore: begin
            expWe    = 1'b0;
            expStore = 1'b1;
            expAddr  = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
            expData  = b;
            modelMem[expAddr[11:2]] = b;
        end
        default: failRun($sformatf("model found no instruction it can run at pc %h", modelPc));
    endcase
    if (expWe && expRd != 5'd0) begin
        modelRegs[expRd] = expVal;
    end
    modelPc = nextPc;
endtask

task automatic checkWord(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
        failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic checkReg(string name, logic [4:0] got, logic [4:0] exp);
    if (got !== exp) begin
        failRun($sformatf("mismatch at %0t: %s got x%0d expected x%0d", $time, name, got, exp));
    end
endtask

task automatic checkPc(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
        failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
endtask

`endif

// ==== dv/coreTb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for rvMultiCore with clock, reset, memory model and retire monitor
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module coreTb;

    localparam logic [31:0] resetAddr  = 32'h0000_0000;
    localparam int          progLen    = 200;
    localparam int          memWords   = 1024;
    localparam int          cycleLimit = progLen * 6 + 100;
    localparam logic [31:0] haltPc     = resetAddr + 32'((progLen - 1) * 4);

    logic        clk;
    logic        rst;
    logic [31:0] memRdata;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [3:0]  memWstrb;
    logic        memRead;
    logic        retire;
    logic [31:0] retirePc;
    logic        regWe;
    logic [4:0]  regWaddr;
    logic [31:0] regWdata;

    logic [31:0] mem [memWords];
    logic        readPending;
    logic [31:0] readAddr;
    logic [31:0] rngState;
    logic        fetchSeen;
    int          cycleCount;
    int          haltRetires;
    int          readCount;

    task automatic failRun(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "tbIsaModel.svh"

    // every address bit goes into the word
    function automatic logic [31:0] fillWord(int idx);
        return (32'(idx) * 32'h9e37_79b9) ^ 32'h5bd1_e995;
    endfunction

    rvMultiCore #(
        .resetAddr(resetAddr),
        .numRegs  (32)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .memAddr (memAddr),
        .memWdata(memWdata),
        .memWstrb(memWstrb),
        .memRead (memRead),
        .memRdata(memRdata),
        .retire  (retire),
        .retirePc(retirePc),
        .regWe   (regWe),
        .regWaddr(regWaddr),
        .regWdata(regWdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        int i;
        rst         = 1'b1;
        memRdata    = 32'd0;
        readPending = 1'b0;
        readAddr    = 32'd0;
        fetchSeen   = 1'b0;
        cycleCount  = 0;
        haltRetires = 0;
        readCount   = 0;
        rngState    = 32'hb8bb_65cf;
        for (i = 0; i < memWords; i++) begin
            mem[i] = fillWord(i);
        end
        buildProgram();
        for (i = 0; i < memWords; i++) begin
            modelMem[i] = mem[i];
        end
        for (i = 0; i < 32; i++) begin
            modelRegs[i] = 32'd0;
        end
        modelPc = resetAddr;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    end

    // synchronous read takes the address at the rising edge
    always @(posedge clk) begin
        if (memWstrb == 4'hf) begin
            mem[memAddr[11:2]] = memWdata;
        end
        readPending = (memRead === 1'b1);
        readAddr    = memAddr;
    end

    // read data goes out on the falling edge and holds
    always @(negedge clk) begin
        if (readPending) begin
            memRdata = mem[readAddr[11:2]];
        end
    end

    task automatic checkRetire();
        logic isLoadInstr;
        isLoadInstr = (modelMem[modelPc[11:2]][6:0] == rvIsaPkg::opLoad);
        checkPc("retirePc", retirePc, modelPc);
        if (retirePc == haltPc) begin
            haltRetires++;
        end
        stepModel();
        checkWord("regWe", {31'd0, regWe}, {31'd0, expWe});
        if (expWe) begin
            checkReg("regWaddr", regWaddr, expRd);
            checkWord("regWdata", regWdata, expVal);
        end
        checkWord("memWstrb", {28'd0, memWstrb}, expStore ? 32'hf : 32'h0);
        if (expStore) begin
            checkWord("memAddr", memAddr, expAddr);
            checkWord("memWdata", memWdata, expData);
        end
        // one fetch read, plus the data read of a load
        checkWord("memRead strobes", 32'(readCount), isLoadInstr ? 32'd2 : 32'd1);
        readCount = 0;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            cycleCount++;
            if (!fetchSeen && (retire || regWe)) begin
                failRun("retire or register write came before the first fetch");
            end
            if (!fetchSeen && memRead) begin
                checkPc("first fetch memAddr", memAddr, resetAddr);
                fetchSeen = 1'b1;
            end
            if (!retire && (regWe || memWstrb != 4'h0)) begin
                failRun("register or memory write in a cycle without retire");
            end
            if (memRead) begin
                readCount++;
            end
            if (retire) begin
                checkRetire();
            end
            if (haltRetires >= 2) begin
                $display("TEST PASSED");
                $finish;
            end else if (cycleCount > cycleLimit) begin
                failRun($sformatf("timeout, halt not reached after %0d cycles", cycleCount));
            end
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+dv
logic/rvIsaPkg.sv
logic/coreCtrlPkg.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/immExtend.sv
logic/datapathUnit.sv
logic/controlUnit.sv
logic/rvMultiCore.sv
dv/coreTb.sv

// ==== Makefile ====
# Verilator build and run of the multicycle core testbench

.PHONY: run clean

run: obj_dir/VcoreTb
	./obj_dir/VcoreTb 2>&1 | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

obj_dir/VcoreTb: filelist.f $(wildcard logic/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module coreTb -f filelist.f -o VcoreTb

clean:
	rm -rf obj_dir sim.log
